// File: iew_pkg.sv
`default_nettype none

package iew_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Architectural registers
    localparam int AREG_ID_BITS = 5;
    localparam int ARFSIZE      = 2 ** AREG_ID_BITS;

    // Physical registers
    localparam int PREG_ID_BITS = 6;
    localparam int PRFSIZE      = 2 ** PREG_ID_BITS;

    localparam int ID_BITS = 4;      // Instruction tag

    localparam int NR_WB_PORTS = 2;  // Port 0 is ALU, port 1 is multiplier
    localparam int NR_FU       = 2;

    // Shift-add multiplier retires one multiplier bit per cycle
    localparam int MUL_CYCLES   = XLEN;
    localparam int MUL_CNT_BITS = $clog2(MUL_CYCLES + 1);

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [PREG_ID_BITS-1:0] preg_t;
    typedef logic [AREG_ID_BITS-1:0] areg_t;
    typedef logic [ID_BITS-1:0]      id_t;

    // Also used as index into the per-unit ready bits
    typedef enum logic [0:0] {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_t;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        SLT   = 4'd7,   // Signed compare
        LUI   = 4'd8,
        AUIPC = 4'd9,
        MUL   = 4'd10   // Only valid on FU_MUL
    } op_t;

endpackage

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile #(
    parameter type entry_t = logic [31:0],
    parameter int NREGS = 32,
    parameter int NREAD = 2,
    parameter int NWRITE = 1,
    parameter entry_t RESET_VALUE = entry_t'(0)
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    // Write ports where the higher index wins on collision
    input  logic [NWRITE-1:0]          we_i,
    input  logic [$clog2(NREGS)-1:0]   waddr_i [NWRITE],
    input  entry_t                     wdata_i [NWRITE],
    // Combinational read ports
    input  logic [$clog2(NREGS)-1:0]   raddr_i [NREAD],
    output entry_t                     rdata_o [NREAD]
);

    entry_t mem [NREGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else begin
            // Last assignment in loop order takes effect
            for (int w = 0; w < NWRITE; w++) begin
                if (we_i[w]) begin
                    mem[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < NREAD; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
        end
    end

endmodule

`default_nettype wire

// File: iew.sv
`default_nettype none

module iew import iew_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // Dispatch from rename
    input  logic                   di_valid_i,
    output logic                   di_ready_o,
    input  id_t                    di_id_i,
    input  xlen_t                  di_pc_i,
    input  fu_t                    di_fu_i,
    input  op_t                    di_op_i,
    input  areg_t                  di_rs1_i,
    input  areg_t                  di_rs2_i,
    input  logic                   di_rs1_used_i,
    input  logic                   di_rs2_used_i,
    input  logic                   di_use_uimm_i,
    input  preg_t                  di_prs1_i,
    input  preg_t                  di_prs2_i,
    input  logic                   di_prs1_renamed_i,
    input  logic                   di_prs2_renamed_i,
    input  preg_t                  di_prd_i,
    input  xlen_t                  di_imm_i,
    // Operands to the function units
    output logic [NR_FU-1:0]       fu_valid_o,
    input  logic [NR_FU-1:0]       fu_ready_i,
    output id_t                    fu_id_o,
    output preg_t                  fu_prd_o,
    output op_t                    fu_op_o,
    output xlen_t                  fu_pc_o,
    output xlen_t                  fu_rs1_o,
    output xlen_t                  fu_rs2_o,
    output xlen_t                  fu_imm_o,
    output logic                   fu_rs2_used_o,
    // Writeback that also feeds the same-cycle bypass
    input  logic [NR_WB_PORTS-1:0] wb_valid_i,
    input  preg_t                  wb_prd_i [NR_WB_PORTS],
    input  xlen_t                  wb_data_i [NR_WB_PORTS],
    // In-order commit
    input  logic                   commit_valid_i,
    input  areg_t                  commit_areg_i,
    input  preg_t                  commit_preg_i
);

    preg_t prf_raddr [3];           // prs1, prs2, commit
    xlen_t prf_rdata [3];
    xlen_t prf_val   [3];           // After bypass
    logic  byp_hit   [3];

    areg_t arf_raddr [2];
    xlen_t arf_rdata [2];
    areg_t arf_waddr [1];
    xlen_t arf_wdata [1];

    logic [NR_WB_PORTS:0] sb_we;
    preg_t                sb_waddr [NR_WB_PORTS+1];
    logic                 sb_wdata [NR_WB_PORTS+1];
    preg_t                sb_raddr [2];
    logic                 sb_rdata [2];

    xlen_t rs1_val, rs2_val;
    logic  rs1_rdy, rs2_rdy;
    logic  ops_rdy;
    logic  accept;

    regfile #(.entry_t(xlen_t), .NREGS(PRFSIZE), .NREAD(3), .NWRITE(NR_WB_PORTS)) u_prf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_valid_i),
        .waddr_i  (wb_prd_i),
        .wdata_i  (wb_data_i),
        .raddr_i  (prf_raddr),
        .rdata_o  (prf_rdata)
    );

    regfile #(.entry_t(xlen_t), .NREGS(ARFSIZE), .NREAD(2), .NWRITE(1)) u_arf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (commit_valid_i),
        .waddr_i  (arf_waddr),
        .wdata_i  (arf_wdata),
        .raddr_i  (arf_raddr),
        .rdata_o  (arf_rdata)
    );

    // One bit per preg that is set when its value is in the PRF
    regfile #(
        .entry_t(logic), .NREGS(PRFSIZE), .NREAD(2), .NWRITE(NR_WB_PORTS + 1),
        .RESET_VALUE(1'b1)
    ) u_scoreboard (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (sb_we),
        .waddr_i  (sb_waddr),
        .wdata_i  (sb_wdata),
        .raddr_i  (sb_raddr),
        .rdata_o  (sb_rdata)
    );

    assign prf_raddr[0] = di_prs1_i;
    assign prf_raddr[1] = di_prs2_i;
    assign prf_raddr[2] = commit_preg_i;
    assign sb_raddr[0]  = di_prs1_i;
    assign sb_raddr[1]  = di_prs2_i;
    assign arf_raddr[0] = di_rs1_i;
    assign arf_raddr[1] = di_rs2_i;

    // Bypass the writeback ports onto every PRF read
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            byp_hit[r] = 1'b0;
            prf_val[r] = prf_rdata[r];
            for (int p = 0; p < NR_WB_PORTS; p++) begin
                if (wb_valid_i[p] && wb_prd_i[p] == prf_raddr[r]) begin
                    byp_hit[r] = 1'b1;
                    prf_val[r] = wb_data_i[p];
                end
            end
        end
    end

    always_comb begin
        rs1_val = '0;       // Unused source reads as zero
        rs1_rdy = 1'b1;
        if (di_rs1_used_i) begin
            if (di_fu_i == FU_ALU && di_op_i == AUIPC) begin
                rs1_val = di_pc_i;
            end else if (di_use_uimm_i) begin
                rs1_val = xlen_t'(di_rs1_i);
            end else if (di_prs1_renamed_i) begin
                rs1_val = prf_val[0];
                rs1_rdy = sb_rdata[0] || byp_hit[0];
            end else begin
                rs1_val = arf_rdata[0];
            end
        end
    end

    always_comb begin
        rs2_val = '0;
        rs2_rdy = 1'b1;
        if (di_rs2_used_i) begin
            if (di_prs2_renamed_i) begin
                rs2_val = prf_val[1];
                rs2_rdy = sb_rdata[1] || byp_hit[1];
            end else begin
                rs2_val = arf_rdata[1];
            end
        end
    end

    assign ops_rdy    = rs1_rdy && rs2_rdy;
    assign di_ready_o = !di_valid_i || (ops_rdy && fu_ready_i[di_fu_i]);
    assign accept     = di_valid_i && di_ready_o;

    always_comb begin
        for (int u = 0; u < NR_FU; u++) begin
            fu_valid_o[u] = di_valid_i && ops_rdy && fu_ready_i[u] && (di_fu_i == fu_t'(u));
        end
    end

    assign fu_id_o       = di_id_i;
    assign fu_prd_o      = di_prd_i;
    assign fu_op_o       = di_op_i;
    assign fu_pc_o       = di_pc_i;
    assign fu_rs1_o      = rs1_val;
    assign fu_rs2_o      = rs2_val;
    assign fu_imm_o      = di_imm_i;
    assign fu_rs2_used_o = di_rs2_used_i;

    // Issue clears prd on port 0, writebacks set on the ports above
    assign sb_we       = {wb_valid_i, accept};
    assign sb_waddr[0] = di_prd_i;
    assign sb_wdata[0] = 1'b0;
    for (genvar p = 0; p < NR_WB_PORTS; p++) begin : g_sb_wb
        assign sb_waddr[p+1] = wb_prd_i[p];
        assign sb_wdata[p+1] = 1'b1;
    end

    // Commit copies preg into areg
    assign arf_waddr[0] = commit_areg_i;
    assign arf_wdata[0] = prf_val[2];

endmodule

`default_nettype wire

// File: alu_unit.sv
`default_nettype none

module alu_unit import iew_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  issue_i,
    input  id_t   id_i,
    input  preg_t prd_i,
    input  op_t   op_i,
    input  xlen_t pc_i,
    input  xlen_t rs1_i,
    input  xlen_t rs2_i,
    input  xlen_t imm_i,
    input  logic  rs2_used_i,
    output logic  ready_o,
    // Writeback port 0
    output logic  wb_valid_o,
    output id_t   wb_id_o,
    output preg_t wb_prd_o,
    output xlen_t wb_data_o
);

    xlen_t op_b;
    xlen_t result;

    assign op_b    = rs2_used_i ? rs2_i : imm_i;
    assign ready_o = 1'b1;              // Takes one instruction every cycle

    always_comb begin
        case (op_i)
            ADD:     result = rs1_i + op_b;
            SUB:     result = rs1_i - op_b;
            AND:     result = rs1_i & op_b;
            OR:      result = rs1_i | op_b;
            XOR:     result = rs1_i ^ op_b;
            SLL:     result = rs1_i << op_b[$clog2(XLEN)-1:0];
            SRL:     result = rs1_i >> op_b[$clog2(XLEN)-1:0];
            SLT:     result = xlen_t'($signed(rs1_i) < $signed(op_b));
            LUI:     result = imm_i;
            AUIPC:   result = pc_i + imm_i;
            default: result = '0;       // MUL goes to the multiplier
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_i;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (issue_i) begin
            wb_id_o   <= id_i;
            wb_prd_o  <= prd_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// File: mul_unit.sv
`default_nettype none

module mul_unit import iew_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  issue_i,
    input  id_t   id_i,
    input  preg_t prd_i,
    input  xlen_t rs1_i,
    input  xlen_t rs2_i,
    input  xlen_t imm_i,
    input  logic  rs2_used_i,
    output logic  ready_o,
    // Writeback port 1
    output logic  wb_valid_o,
    output id_t   wb_id_o,
    output preg_t wb_prd_o,
    output xlen_t wb_data_o
);

    xlen_t                   op_b;
    xlen_t                   acc;       // Partial product
    xlen_t                   mcand;     // Multiplicand, shifted left each step
    xlen_t                   mplier;    // Multiplier, shifted right each step
    logic                    busy;
    logic [MUL_CNT_BITS-1:0] cnt;       // Steps left

    assign op_b      = rs2_used_i ? rs2_i : imm_i;
    assign ready_o   = !busy;
    assign wb_data_o = acc;

    // Bit 0 handled at issue, remaining bits one per cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy       <= 1'b0;
            wb_valid_o <= 1'b0;
            cnt        <= '0;
        end else if (issue_i) begin
            busy <= 1'b1;
            cnt  <= MUL_CNT_BITS'(MUL_CYCLES - 1);
        end else if (wb_valid_o) begin
            busy       <= 1'b0;     // Free again after the writeback cycle
            wb_valid_o <= 1'b0;
        end else if (busy) begin
            cnt        <= cnt - 1'b1;
            wb_valid_o <= (cnt == MUL_CNT_BITS'(1));  // Last step
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            acc      <= op_b[0] ? rs1_i : '0;
            mcand    <= rs1_i << 1;
            mplier   <= op_b >> 1;
            wb_id_o  <= id_i;
            wb_prd_o <= prd_i;
        end else if (busy && !wb_valid_o) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// File: exec_top.sv
`default_nettype none

module exec_top import iew_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // Dispatch
    input  logic                   di_valid_i,
    output logic                   di_ready_o,
    input  id_t                    di_id_i,
    input  xlen_t                  di_pc_i,
    input  fu_t                    di_fu_i,
    input  op_t                    di_op_i,
    input  areg_t                  di_rs1_i,
    input  areg_t                  di_rs2_i,
    input  logic                   di_rs1_used_i,
    input  logic                   di_rs2_used_i,
    input  logic                   di_use_uimm_i,
    input  preg_t                  di_prs1_i,
    input  preg_t                  di_prs2_i,
    input  logic                   di_prs1_renamed_i,
    input  logic                   di_prs2_renamed_i,
    input  preg_t                  di_prd_i,
    input  xlen_t                  di_imm_i,
    // Commit
    input  logic                   commit_valid_i,
    input  areg_t                  commit_areg_i,
    input  preg_t                  commit_preg_i,
    // Writeback ports
    output logic [NR_WB_PORTS-1:0] wb_valid_o,
    output id_t                    wb_id_o [NR_WB_PORTS],
    output preg_t                  wb_prd_o [NR_WB_PORTS],
    output xlen_t                  wb_data_o [NR_WB_PORTS]
);

    logic [NR_FU-1:0] fu_valid;
    logic [NR_FU-1:0] fu_ready;
    id_t              fu_id;
    preg_t            fu_prd;
    op_t              fu_op;
    xlen_t            fu_pc, fu_rs1, fu_rs2, fu_imm;
    logic             fu_rs2_used;

    iew u_iew (
        .clk (clk), .arst_n_i (arst_n_i),
        .di_valid_i (di_valid_i), .di_ready_o (di_ready_o),
        .di_id_i (di_id_i), .di_pc_i (di_pc_i), .di_fu_i (di_fu_i), .di_op_i (di_op_i),
        .di_rs1_i (di_rs1_i), .di_rs2_i (di_rs2_i),
        .di_rs1_used_i (di_rs1_used_i), .di_rs2_used_i (di_rs2_used_i),
        .di_use_uimm_i (di_use_uimm_i),
        .di_prs1_i (di_prs1_i), .di_prs2_i (di_prs2_i),
        .di_prs1_renamed_i (di_prs1_renamed_i), .di_prs2_renamed_i (di_prs2_renamed_i),
        .di_prd_i (di_prd_i), .di_imm_i (di_imm_i),
        .fu_valid_o (fu_valid), .fu_ready_i (fu_ready),
        .fu_id_o (fu_id), .fu_prd_o (fu_prd), .fu_op_o (fu_op), .fu_pc_o (fu_pc),
        .fu_rs1_o (fu_rs1), .fu_rs2_o (fu_rs2), .fu_imm_o (fu_imm),
        .fu_rs2_used_o (fu_rs2_used),
        .wb_valid_i (wb_valid_o), .wb_prd_i (wb_prd_o), .wb_data_i (wb_data_o),
        .commit_valid_i (commit_valid_i), .commit_areg_i (commit_areg_i),
        .commit_preg_i (commit_preg_i)
    );

    alu_unit u_alu (
        .clk (clk), .arst_n_i (arst_n_i), .issue_i (fu_valid[FU_ALU]),
        .id_i (fu_id), .prd_i (fu_prd), .op_i (fu_op), .pc_i (fu_pc),
        .rs1_i (fu_rs1), .rs2_i (fu_rs2), .imm_i (fu_imm), .rs2_used_i (fu_rs2_used),
        .ready_o (fu_ready[FU_ALU]),
        .wb_valid_o (wb_valid_o[0]), .wb_id_o (wb_id_o[0]),
        .wb_prd_o (wb_prd_o[0]), .wb_data_o (wb_data_o[0])
    );

    mul_unit u_mul (
        .clk (clk), .arst_n_i (arst_n_i), .issue_i (fu_valid[FU_MUL]),
        .id_i (fu_id), .prd_i (fu_prd),
        .rs1_i (fu_rs1), .rs2_i (fu_rs2), .imm_i (fu_imm), .rs2_used_i (fu_rs2_used),
        .ready_o (fu_ready[FU_MUL]),
        .wb_valid_o (wb_valid_o[1]), .wb_id_o (wb_id_o[1]),
        .wb_prd_o (wb_prd_o[1]), .wb_data_o (wb_data_o[1])
    );

endmodule

`default_nettype wire

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    id_t   id;
    preg_t prd;
    xlen_t data;
    int    cycle;       // Cycle in which the writeback is due
} wb_exp_t;

typedef struct packed {
    areg_t areg;
    preg_t preg;
} commit_t;

xlen_t   preg_val     [PRFSIZE];
logic    preg_pending [PRFSIZE];   // Issued, result not yet written back
xlen_t   arf_val      [ARFSIZE];
int      free_list    [$];
wb_exp_t alu_q        [$];
wb_exp_t mul_q        [$];
commit_t commit_q     [$];         // Program order
logic    mul_busy;

task automatic reset_model();
    for (int i = 0; i < PRFSIZE; i++) begin
        preg_val[i]     = '0;
        preg_pending[i] = 1'b0;
        free_list.push_back(i);
    end
    for (int i = 0; i < ARFSIZE; i++) begin
        arf_val[i] = '0;
    end
    mul_busy = 1'b0;
endtask

function automatic xlen_t src1_value();
    if (!di_rs1_used_i) return '0;
    if (di_fu_i == FU_ALU && di_op_i == AUIPC) return di_pc_i;
    if (di_use_uimm_i) return xlen_t'(di_rs1_i);
    if (di_prs1_renamed_i) return preg_val[di_prs1_i];
    return arf_val[di_rs1_i];
endfunction

function automatic xlen_t src2_value();
    if (!di_rs2_used_i) return '0;
    if (di_prs2_renamed_i) return preg_val[di_prs2_i];
    return arf_val[di_rs2_i];
endfunction

// True while a renamed source still waits for its producer
function automatic logic src_waits();
    logic rs1_prf;
    logic rs2_prf;
    rs1_prf = di_rs1_used_i && di_prs1_renamed_i && !di_use_uimm_i
              && !(di_fu_i == FU_ALU && di_op_i == AUIPC);
    rs2_prf = di_rs2_used_i && di_prs2_renamed_i;
    return (rs1_prf && preg_pending[di_prs1_i]) || (rs2_prf && preg_pending[di_prs2_i]);
endfunction

function automatic xlen_t compute_result(fu_t fu, op_t op, xlen_t a, xlen_t b,
                                         xlen_t pc, xlen_t imm);
    if (fu == FU_MUL) return a * b;   // Low half of the product
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLL:     return a << b[4:0];
        SRL:     return a >> b[4:0];
        SLT:     return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
        LUI:     return imm;
        AUIPC:   return pc + imm;
        default: return '0;
    endcase
endfunction

function automatic xlen_t expected_result();
    xlen_t a;
    xlen_t b;
    a = src1_value();
    b = di_rs2_used_i ? src2_value() : di_imm_i;   // Immediate as second operand
    return compute_result(di_fu_i, di_op_i, a, b, di_pc_i, di_imm_i);
endfunction

`endif

// File: tb_exec.sv
`default_nettype none

module tb_exec import iew_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_INSTR    = 400;
    localparam int          TIMEOUT      = NUM_INSTR * (MUL_CYCLES + 4) * CLK_PERIOD;
    localparam int unsigned SEED         = 32'h3c9c_5b2b;

    logic                   clk;
    logic                   arst_n_i;
    logic                   di_valid_i, di_ready_o;
    id_t                    di_id_i;
    xlen_t                  di_pc_i, di_imm_i;
    fu_t                    di_fu_i;
    op_t                    di_op_i;
    areg_t                  di_rs1_i, di_rs2_i;
    logic                   di_rs1_used_i, di_rs2_used_i, di_use_uimm_i;
    preg_t                  di_prs1_i, di_prs2_i, di_prd_i;
    logic                   di_prs1_renamed_i, di_prs2_renamed_i;
    logic                   commit_valid_i;
    areg_t                  commit_areg_i;
    preg_t                  commit_preg_i;
    logic [NR_WB_PORTS-1:0] wb_valid_o;
    id_t                    wb_id_o   [NR_WB_PORTS];
    preg_t                  wb_prd_o  [NR_WB_PORTS];
    xlen_t                  wb_data_o [NR_WB_PORTS];

    int    cycle;
    logic  accepted;        // Set by the monitor, consumed by the driver
    areg_t cur_rd;
    preg_t recent_prd;

    `include "tb_model.svh"

    exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(TIMEOUT + RESET_CYCLES * CLK_PERIOD);
        report_failure("Timeout: the run did not finish in the expected time");
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act)
        else report_failure($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, act));
    endtask

    task automatic check_wb_port(string name, wb_exp_t e, int p);
        check_value({name, " cycle"}, e.cycle, cycle);
        check_value({name, " id"}, e.id, wb_id_o[p]);
        check_value({name, " prd"}, e.prd, wb_prd_o[p]);
        check_value({name, " data"}, e.data, wb_data_o[p]);
        preg_pending[e.prd] = 1'b0;
    endtask

    // Runs mid-cycle when all DUT outputs are settled
    task automatic check_cycle();
        logic  exp_ready;
        xlen_t res;
        if (wb_valid_o[0]) begin
            assert (alu_q.size() > 0) else report_failure("ALU writeback with nothing in flight");
            check_wb_port("alu_wb", alu_q.pop_front(), 0);
        end else if (alu_q.size() > 0) begin
            assert (alu_q[0].cycle > cycle) else report_failure("ALU writeback missing when due");
        end
        if (wb_valid_o[1]) begin
            assert (mul_q.size() > 0) else report_failure("MUL writeback with nothing in flight");
            check_wb_port("mul_wb", mul_q.pop_front(), 1);
        end else if (mul_q.size() > 0) begin
            assert (mul_q[0].cycle > cycle) else report_failure("MUL writeback missing when due");
        end
        // Sources written back this cycle already count as ready
        exp_ready = !di_valid_i || (!src_waits() && (di_fu_i == FU_ALU || !mul_busy));
        check_value("dispatch ready", exp_ready, di_ready_o);
        if (wb_valid_o[1]) begin
            mul_busy = 1'b0;
        end
        if (di_valid_i && di_ready_o) begin
            res = expected_result();
            if (di_fu_i == FU_ALU) begin
                alu_q.push_back('{di_id_i, di_prd_i, res, cycle + 1});
            end else begin
                mul_q.push_back('{di_id_i, di_prd_i, res, cycle + MUL_CYCLES});
                mul_busy = 1'b1;
            end
            preg_val[di_prd_i]     = res;
            preg_pending[di_prd_i] = 1'b1;
            commit_q.push_back('{cur_rd, di_prd_i});
            recent_prd = di_prd_i;
            accepted   = 1'b1;
        end
        if (commit_valid_i) begin      // ARF changes at the coming edge
            arf_val[commit_areg_i] = preg_val[commit_preg_i];
            free_list.push_back(commit_preg_i);
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n_i) begin
            assert (wb_valid_o == '0) else report_failure("Writeback valid high during reset");
        end else begin
            cycle++;
            check_cycle();
        end
    end

    // Often the latest destination, so dependants see it pending
    function automatic preg_t pick_source_preg();
        return ($urandom % 2) ? recent_prd : preg_t'($urandom);
    endfunction

    task automatic gen_instr(int n);
        logic is_mul;
        is_mul            = ($urandom % 4) == 0;
        di_id_i           = id_t'(n);
        di_pc_i           = $urandom;
        di_fu_i           = is_mul ? FU_MUL : FU_ALU;
        di_op_i           = is_mul ? MUL : op_t'(4'($urandom % 10));
        di_rs1_i          = areg_t'($urandom);
        di_rs2_i          = areg_t'($urandom);
        di_rs1_used_i     = ($urandom % 8) != 0;
        di_rs2_used_i     = ($urandom % 2) == 1;
        di_use_uimm_i     = ($urandom % 8) == 0;
        di_prs1_i         = pick_source_preg();
        di_prs2_i         = pick_source_preg();
        di_prs1_renamed_i = ($urandom % 4) != 0;
        di_prs2_renamed_i = ($urandom % 4) != 0;
        di_prd_i          = preg_t'(free_list.pop_front());
        di_imm_i          = ($urandom % 2) ? $urandom : ($urandom % 64);  // Small for shifts
        cur_rd            = areg_t'($urandom);
        di_valid_i        = 1'b1;
    endtask

    // In order, once the head has written back
    task automatic drive_commit();
        commit_t c;
        commit_valid_i = 1'b0;
        if (commit_q.size() > 0 && ($urandom % 4) != 0) begin
            if (!preg_pending[commit_q[0].preg]) begin
                c              = commit_q.pop_front();
                commit_valid_i = 1'b1;
                commit_areg_i  = c.areg;
                commit_preg_i  = c.preg;
            end
        end
    endtask

    initial begin
        int n;
        void'($urandom(SEED));
        arst_n_i          = 1'b0;
        di_valid_i        = 1'b0;
        di_id_i           = '0;
        di_pc_i           = '0;
        di_fu_i           = FU_ALU;
        di_op_i           = ADD;
        di_rs1_i          = '0;
        di_rs2_i          = '0;
        di_rs1_used_i     = 1'b0;
        di_rs2_used_i     = 1'b0;
        di_use_uimm_i     = 1'b0;
        di_prs1_i         = '0;
        di_prs2_i         = '0;
        di_prs1_renamed_i = 1'b0;
        di_prs2_renamed_i = 1'b0;
        di_prd_i          = '0;
        di_imm_i          = '0;
        commit_valid_i    = 1'b0;
        commit_areg_i     = '0;
        commit_preg_i     = '0;
        cycle             = 0;
        accepted          = 1'b0;
        cur_rd            = '0;
        recent_prd        = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        n = 0;
        while (n < NUM_INSTR || di_valid_i || commit_q.size() > 0) begin
            @(posedge clk);
            #DRIVE_DLY;
            drive_commit();
            if (!di_valid_i || accepted) begin
                accepted = 1'b0;
                if (n < NUM_INSTR && free_list.size() > 0 && ($urandom % 8) != 0) begin
                    gen_instr(n);
                    n++;
                end else begin
                    di_valid_i = 1'b0;   // Idle cycle
                end
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        commit_valid_i = 1'b0;
        repeat (2) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
iew_pkg.sv
regfile.sv
iew.sv
alu_unit.sv
mul_unit.sv
exec_top.sv
tb_exec.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT      = --lint-only -Wall
TOP       = tb_exec
RTL_TOP   = exec_top
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
